// ==== rtl/dsp_pkg.sv ====
package dsp_pkg;

    // ================================================
    // Widths
    // ================================================
    localparam int CMD_W      = 128;
    localparam int TIME_W     = 32;
    localparam int FREQ_W     = 9;
    localparam int PHASE_W    = 17;
    localparam int AMP_W      = 16;
    localparam int CFG_W      = 4;
    localparam int ENV_WORD_W = 24;
    localparam int SAMPLE_W   = 16;
    localparam int ADC_W      = 16;
    localparam int ACC_W      = 40;

    // Command field positions, bits 102 to 127 reserved
    localparam int CMD_TIME_LSB  = 0;
    localparam int CMD_FREQ_LSB  = 32;
    localparam int CMD_PHASE_LSB = 41;
    localparam int CMD_AMP_LSB   = 58;
    localparam int CMD_CFG_LSB   = 74;
    localparam int CMD_ENV_LSB   = 78;

    // Queue and envelope memory sizes
    localparam int CMD_DEPTH   = 4;
    localparam int QDRV_ENV_AW = 10;
    localparam int RD_ENV_AW   = 12;

    // Element selector in cfg[1:0], code 3 drops the command
    localparam logic [1:0] ELEM_QDRV = 2'd0;
    localparam logic [1:0] ELEM_RDRV = 2'd1;
    localparam logic [1:0] ELEM_RDLO = 2'd2;

    localparam int SAMPLE_SHIFT = 15;
    localparam int MIX_SHIFT    = 8;

    // ================================================
    // Envelope word, qdrv and readout layouts
    // ================================================
    typedef union packed {
        struct packed {
            logic [RD_ENV_AW-QDRV_ENV_AW-1:0] rsvd_hi;
            logic [QDRV_ENV_AW-1:0]           length;
            logic [RD_ENV_AW-QDRV_ENV_AW-1:0] rsvd_lo;
            logic [QDRV_ENV_AW-1:0]           start;
        } q;
        struct packed {
            logic [RD_ENV_AW-1:0] length;
            logic [RD_ENV_AW-1:0] start;
        } rd;
    } env_word_u;

endpackage

// ==== rtl/proc_core.sv ====
module proc_core (
    input  logic                           dspif,
    input  logic                           rst_n,
    input  logic [dsp_pkg::TIME_W-1:0]     tcnt,
    input  logic                           cmd_valid,
    input  logic [dsp_pkg::CMD_W-1:0]      cmd,
    output logic                           cmd_credit,
    output logic                           qdrv_stb,
    output logic                           rdrv_stb,
    output logic                           rdlo_stb,
    output logic [dsp_pkg::FREQ_W-1:0]     freq,
    output logic [dsp_pkg::PHASE_W-1:0]    phase,
    output logic [dsp_pkg::AMP_W-1:0]      amp,
    output dsp_pkg::env_word_u             env_word
);

    localparam int PTR_W = $clog2(dsp_pkg::CMD_DEPTH);
    localparam int CNT_W = $clog2(dsp_pkg::CMD_DEPTH + 1);

    logic [dsp_pkg::CMD_W-1:0]  queue [dsp_pkg::CMD_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           count;

    logic [dsp_pkg::CMD_W-1:0]  head;
    logic [dsp_pkg::TIME_W-1:0] head_time;
    logic [dsp_pkg::CFG_W-1:0]  head_cfg;
    logic                       issue;

    // ================================================
    // Command queue
    // ================================================

    // Host spends credits, so a push never lands on a full queue
    always_ff @(posedge dspif) begin
        if (cmd_valid) begin
            queue[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge dspif or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(dsp_pkg::CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (issue) begin
                rd_ptr <= (rd_ptr == PTR_W'(dsp_pkg::CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(cmd_valid) - CNT_W'(issue);
        end
    end

    // ================================================
    // Time-triggered issue
    // ================================================
    assign head      = queue[rd_ptr];
    assign head_time = head[dsp_pkg::CMD_TIME_LSB +: dsp_pkg::TIME_W];
    assign head_cfg  = head[dsp_pkg::CMD_CFG_LSB +: dsp_pkg::CFG_W];

    // Head leaves once its trigger time has been reached
    assign issue = (count != '0) && (head_time <= tcnt);

    always_ff @(posedge dspif or negedge rst_n) begin
        if (!rst_n) begin
            cmd_credit <= 1'b0;
            qdrv_stb   <= 1'b0;
            rdrv_stb   <= 1'b0;
            rdlo_stb   <= 1'b0;
        end else begin
            // Every popped slot returns a credit, dropped commands too
            cmd_credit <= issue;
            qdrv_stb   <= issue && (head_cfg[1:0] == dsp_pkg::ELEM_QDRV);
            rdrv_stb   <= issue && (head_cfg[1:0] == dsp_pkg::ELEM_RDRV);
            rdlo_stb   <= issue && (head_cfg[1:0] == dsp_pkg::ELEM_RDLO);
        end
    end

    // Decoded fields, held until the next issue
    // Mode bits cfg[3:2] ride along in the queue but have no use yet
    always_ff @(posedge dspif) begin
        if (issue) begin
            freq     <= head[dsp_pkg::CMD_FREQ_LSB +: dsp_pkg::FREQ_W];
            phase    <= head[dsp_pkg::CMD_PHASE_LSB +: dsp_pkg::PHASE_W];
            amp      <= head[dsp_pkg::CMD_AMP_LSB +: dsp_pkg::AMP_W];
            env_word <= head[dsp_pkg::CMD_ENV_LSB +: dsp_pkg::ENV_WORD_W];
        end
    end

endmodule

// ==== rtl/envelope_mem.sv ====
module envelope_mem #(
    parameter int AW = dsp_pkg::QDRV_ENV_AW
) (
    input  logic                         dspif,
    input  logic                         we,
    input  logic [AW-1:0]                waddr,
    input  logic [dsp_pkg::SAMPLE_W-1:0] wdata,
    input  logic [AW-1:0]                rd_addr,
    output logic [dsp_pkg::SAMPLE_W-1:0] rd_data
);

    logic [dsp_pkg::SAMPLE_W-1:0] mem [2**AW];

    // Host write port
    always_ff @(posedge dspif) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Element read port, one cycle latency
    always_ff @(posedge dspif) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== rtl/pulse_element.sv ====
module pulse_element #(
    parameter int AW = dsp_pkg::QDRV_ENV_AW
) (
    input  logic                         dspif,
    input  logic                         rst_n,
    input  logic                         stb,
    input  logic [dsp_pkg::FREQ_W-1:0]   freq,
    input  logic [dsp_pkg::PHASE_W-1:0]  phase,
    input  logic [dsp_pkg::AMP_W-1:0]    amp,
    input  dsp_pkg::env_word_u           env_word,
    output logic [AW-1:0]                rd_addr,
    input  logic [dsp_pkg::SAMPLE_W-1:0] rd_data,
    output logic                         sample_valid,
    output logic [dsp_pkg::SAMPLE_W-1:0] sample,
    output logic                         last,
    output logic [dsp_pkg::PHASE_W-1:0]  phase_out
);

    localparam int PROD_W = dsp_pkg::SAMPLE_W + dsp_pkg::AMP_W;

    logic [AW-1:0]                      env_start;
    logic [AW-1:0]                      env_len;
    logic [AW-1:0]                      addr;
    logic [AW-1:0]                      remain;
    logic                               active;
    logic                               rd_valid;
    logic                               rd_last;
    logic                               data_valid;
    logic                               data_last;
    logic signed [dsp_pkg::AMP_W-1:0]   amp_r;
    logic [dsp_pkg::FREQ_W-1:0]         freq_r;
    logic [dsp_pkg::PHASE_W-1:0]        phase_acc;
    logic signed [PROD_W-1:0]           prod;
    logic signed [PROD_W-1:0]           prod_sh;

    // Envelope word layout follows the memory size
    generate
        if (AW == dsp_pkg::QDRV_ENV_AW) begin : g_qdrv_view
            assign env_start = env_word.q.start;
            assign env_len   = env_word.q.length;
        end else begin : g_rd_view
            assign env_start = env_word.rd.start;
            assign env_len   = env_word.rd.length;
        end
    endgenerate

    // ================================================
    // Address walk
    // ================================================

    // First read goes out in the strobe cycle itself
    always_comb begin
        if (stb) begin
            rd_addr  = env_start;
            rd_valid = (env_len != '0);
            rd_last  = (env_len == AW'(1));
        end else begin
            rd_addr  = addr;
            rd_valid = active;
            rd_last  = active && (remain == AW'(1));
        end
    end

    always_ff @(posedge dspif or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            addr   <= '0;
            remain <= '0;
        end else if (stb) begin
            addr   <= env_start + 1'b1;
            remain <= env_len - 1'b1;
            active <= (env_len > AW'(1));
        end else if (active) begin
            addr   <= addr + 1'b1;
            remain <= remain - 1'b1;
            active <= (remain > AW'(1));
        end
    end

    // ================================================
    // Scale and phase
    // ================================================
    always_ff @(posedge dspif) begin
        if (stb) begin
            amp_r  <= amp;
            freq_r <= freq;
        end
    end

    assign prod    = $signed(rd_data) * amp_r;
    assign prod_sh = prod >>> dsp_pkg::SAMPLE_SHIFT;

    always_ff @(posedge dspif) begin
        if (stb) begin
            phase_acc <= phase;
        end else if (data_valid) begin
            phase_acc <= phase_acc + {{(dsp_pkg::PHASE_W - dsp_pkg::FREQ_W){1'b0}}, freq_r};
        end
    end

    always_ff @(posedge dspif) begin
        if (data_valid) begin
            sample    <= prod_sh[dsp_pkg::SAMPLE_W-1:0];
            phase_out <= phase_acc;
        end
    end

    // Valid and last follow the reads through memory and multiplier
    always_ff @(posedge dspif or negedge rst_n) begin
        if (!rst_n) begin
            data_valid   <= 1'b0;
            data_last    <= 1'b0;
            sample_valid <= 1'b0;
            last         <= 1'b0;
        end else begin
            data_valid   <= rd_valid;
            data_last    <= rd_last;
            sample_valid <= data_valid;
            last         <= data_last;
        end
    end

endmodule

// ==== rtl/readout_acc.sv ====
module readout_acc (
    input  logic                         dspif,
    input  logic                         rst_n,
    input  logic                         sample_valid,
    input  logic [dsp_pkg::SAMPLE_W-1:0] sample,
    input  logic                         last,
    input  logic [dsp_pkg::ADC_W-1:0]    adc,
    output logic                         acc_valid,
    output logic [dsp_pkg::ACC_W-1:0]    acc_x
);

    localparam int MIX_W = dsp_pkg::ADC_W + dsp_pkg::SAMPLE_W;

    logic signed [MIX_W-1:0]          mix;
    logic signed [MIX_W-1:0]          mix_sh;
    logic signed [dsp_pkg::ACC_W-1:0] term;
    logic                             in_pulse;

    // ================================================
    // Mix and accumulate
    // ================================================
    assign mix    = $signed(adc) * $signed(sample);
    assign mix_sh = mix >>> dsp_pkg::MIX_SHIFT;
    assign term   = {{(dsp_pkg::ACC_W - MIX_W){mix_sh[MIX_W-1]}}, mix_sh};

    // First sample of a pulse restarts the sum
    always_ff @(posedge dspif) begin
        if (sample_valid) begin
            acc_x <= (in_pulse ? acc_x : '0) + term;
        end
    end

    always_ff @(posedge dspif or negedge rst_n) begin
        if (!rst_n) begin
            in_pulse  <= 1'b0;
            acc_valid <= 1'b0;
        end else begin
            if (sample_valid) begin
                in_pulse <= !last;
            end
            // Sum is complete the cycle after the last sample
            acc_valid <= sample_valid && last;
        end
    end

endmodule

// ==== rtl/dsp.sv ====
module dsp (
    input  logic                          dspif,
    input  logic                          rst_n,
    input  logic                          cmd_valid,
    input  logic [dsp_pkg::CMD_W-1:0]     cmd,
    output logic                          cmd_credit,
    input  logic                          env_we,
    input  logic [1:0]                    env_sel,
    input  logic [dsp_pkg::RD_ENV_AW-1:0] env_waddr,
    input  logic [dsp_pkg::SAMPLE_W-1:0]  env_wdata,
    input  logic [dsp_pkg::ADC_W-1:0]     adc,
    output logic [dsp_pkg::TIME_W-1:0]    tcnt,
    output logic                          qdrv_valid,
    output logic [dsp_pkg::SAMPLE_W-1:0]  qdrv_sample,
    output logic [dsp_pkg::PHASE_W-1:0]   qdrv_phase,
    output logic                          rdrv_valid,
    output logic [dsp_pkg::SAMPLE_W-1:0]  rdrv_sample,
    output logic [dsp_pkg::PHASE_W-1:0]   rdrv_phase,
    output logic                          acc_valid,
    output logic [dsp_pkg::ACC_W-1:0]     acc_x
);

    logic                            qdrv_stb;
    logic                            rdrv_stb;
    logic                            rdlo_stb;
    logic [dsp_pkg::FREQ_W-1:0]      freq;
    logic [dsp_pkg::PHASE_W-1:0]     phase;
    logic [dsp_pkg::AMP_W-1:0]       amp;
    dsp_pkg::env_word_u              env_word;

    logic                            qdrv_we;
    logic                            rdrv_we;
    logic                            rdlo_we;
    logic [dsp_pkg::QDRV_ENV_AW-1:0] qdrv_addr;
    logic [dsp_pkg::RD_ENV_AW-1:0]   rdrv_addr;
    logic [dsp_pkg::RD_ENV_AW-1:0]   rdlo_addr;
    logic [dsp_pkg::SAMPLE_W-1:0]    qdrv_env;
    logic [dsp_pkg::SAMPLE_W-1:0]    rdrv_env;
    logic [dsp_pkg::SAMPLE_W-1:0]    rdlo_env;
    logic                            rdlo_valid;
    logic [dsp_pkg::SAMPLE_W-1:0]    rdlo_sample;
    logic                            rdlo_last;

    // ================================================
    // Time base
    // ================================================
    always_ff @(posedge dspif or negedge rst_n) begin
        if (!rst_n) begin
            tcnt <= '0;
        end else begin
            tcnt <= tcnt + 1'b1;
        end
    end

    proc_core i_core (
        .dspif      (dspif),
        .rst_n      (rst_n),
        .tcnt       (tcnt),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .qdrv_stb   (qdrv_stb),
        .rdrv_stb   (rdrv_stb),
        .rdlo_stb   (rdlo_stb),
        .freq       (freq),
        .phase      (phase),
        .amp        (amp),
        .env_word   (env_word)
    );

    // Envelope host writes go to the memory named by env_sel
    assign qdrv_we = env_we && (env_sel == dsp_pkg::ELEM_QDRV);
    assign rdrv_we = env_we && (env_sel == dsp_pkg::ELEM_RDRV);
    assign rdlo_we = env_we && (env_sel == dsp_pkg::ELEM_RDLO);

    // ================================================
    // Pulse elements
    // ================================================
    envelope_mem #(.AW(dsp_pkg::QDRV_ENV_AW)) i_qdrv_mem (
        .dspif   (dspif),
        .we      (qdrv_we),
        .waddr   (env_waddr[dsp_pkg::QDRV_ENV_AW-1:0]),
        .wdata   (env_wdata),
        .rd_addr (qdrv_addr),
        .rd_data (qdrv_env)
    );

    pulse_element #(.AW(dsp_pkg::QDRV_ENV_AW)) i_qdrv (
        .dspif        (dspif),
        .rst_n        (rst_n),
        .stb          (qdrv_stb),
        .freq         (freq),
        .phase        (phase),
        .amp          (amp),
        .env_word     (env_word),
        .rd_addr      (qdrv_addr),
        .rd_data      (qdrv_env),
        .sample_valid (qdrv_valid),
        .sample       (qdrv_sample),
        .last         (),
        .phase_out    (qdrv_phase)
    );

    envelope_mem #(.AW(dsp_pkg::RD_ENV_AW)) i_rdrv_mem (
        .dspif   (dspif),
        .we      (rdrv_we),
        .waddr   (env_waddr),
        .wdata   (env_wdata),
        .rd_addr (rdrv_addr),
        .rd_data (rdrv_env)
    );

    pulse_element #(.AW(dsp_pkg::RD_ENV_AW)) i_rdrv (
        .dspif        (dspif),
        .rst_n        (rst_n),
        .stb          (rdrv_stb),
        .freq         (freq),
        .phase        (phase),
        .amp          (amp),
        .env_word     (env_word),
        .rd_addr      (rdrv_addr),
        .rd_data      (rdrv_env),
        .sample_valid (rdrv_valid),
        .sample       (rdrv_sample),
        .last         (),
        .phase_out    (rdrv_phase)
    );

    envelope_mem #(.AW(dsp_pkg::RD_ENV_AW)) i_rdlo_mem (
        .dspif   (dspif),
        .we      (rdlo_we),
        .waddr   (env_waddr),
        .wdata   (env_wdata),
        .rd_addr (rdlo_addr),
        .rd_data (rdlo_env)
    );

    pulse_element #(.AW(dsp_pkg::RD_ENV_AW)) i_rdlo (
        .dspif        (dspif),
        .rst_n        (rst_n),
        .stb          (rdlo_stb),
        .freq         (freq),
        .phase        (phase),
        .amp          (amp),
        .env_word     (env_word),
        .rd_addr      (rdlo_addr),
        .rd_data      (rdlo_env),
        .sample_valid (rdlo_valid),
        .sample       (rdlo_sample),
        .last         (rdlo_last),
        .phase_out    ()
    );

    // Readout mixing against the ADC
    readout_acc i_acc (
        .dspif        (dspif),
        .rst_n        (rst_n),
        .sample_valid (rdlo_valid),
        .sample       (rdlo_sample),
        .last         (rdlo_last),
        .adc          (adc),
        .acc_valid    (acc_valid),
        .acc_x        (acc_x)
    );

endmodule

// ==== test/dsp_assertions.sv ====
module dsp_assertions (
    input logic                                       dspif,
    input logic                                       rst_n,
    input logic                                       cmd_valid,
    input logic [$clog2(dsp_pkg::CMD_DEPTH + 1)-1:0] count,
    input logic                                       cmd_credit,
    input logic                                       qdrv_stb,
    input logic                                       rdrv_stb,
    input logic                                       rdlo_stb
);

    timeunit 1ns;
    timeprecision 1ps;

    // ==================================================
    // Queue occupancy and host credit discipline
    // ==================================================
    occupancy_bound: assert property (@(posedge dspif) disable iff (!rst_n)
        count <= dsp_pkg::CMD_DEPTH)
        else $error("queue occupancy above depth");

    no_push_when_full: assert property (@(posedge dspif) disable iff (!rst_n)
        cmd_valid |-> (count < dsp_pkg::CMD_DEPTH))
        else $error("command pushed into a full queue");

    // Only one element fires per issue
    one_strobe: assert property (@(posedge dspif) disable iff (!rst_n)
        $onehot0({qdrv_stb, rdrv_stb, rdlo_stb}))
        else $error("more than one element strobe high");

    quiet_in_reset: assert property (@(posedge dspif)
        !rst_n |-> !(cmd_credit || qdrv_stb || rdrv_stb || rdlo_stb))
        else $error("strobe or credit high during reset");

endmodule

bind proc_core dsp_assertions i_assertions (
    .dspif      (dspif),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .count      (count),
    .cmd_credit (cmd_credit),
    .qdrv_stb   (qdrv_stb),
    .rdrv_stb   (rdrv_stb),
    .rdlo_stb   (rdlo_stb)
);

// ==== test/dsp_tb.sv ====
module dsp_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // The long rdrv pulse dominates the roughly 2500 cycles of tests
    localparam int MAX_CYCLES = 4000;

    logic                          dspif = 1'b0;
    logic                          rst_n;
    logic                          cmd_valid;
    logic [dsp_pkg::CMD_W-1:0]     cmd;
    logic                          cmd_credit;
    logic                          env_we;
    logic [1:0]                    env_sel;
    logic [dsp_pkg::RD_ENV_AW-1:0] env_waddr;
    logic [dsp_pkg::SAMPLE_W-1:0]  env_wdata;
    logic [dsp_pkg::ADC_W-1:0]     adc;
    logic [dsp_pkg::TIME_W-1:0]    tcnt;
    logic                          qdrv_valid;
    logic [dsp_pkg::SAMPLE_W-1:0]  qdrv_sample;
    logic [dsp_pkg::PHASE_W-1:0]   qdrv_phase;
    logic                          rdrv_valid;
    logic [dsp_pkg::SAMPLE_W-1:0]  rdrv_sample;
    logic [dsp_pkg::PHASE_W-1:0]   rdrv_phase;
    logic                          acc_valid;
    logic [dsp_pkg::ACC_W-1:0]     acc_x;

    logic [31:0] lfsr_state = 32'he01;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          sent = 0;
    int          returned = 0;
    logic [31:0] prev_tcnt;
    bit          tcnt_seen = 1'b0;
    logic [15:0] env_model [3][4096];
    logic [15:0] adc_hist [int];
    logic [15:0] q_samp [$];
    logic [16:0] q_phase [$];
    logic [31:0] q_time [$];
    logic [15:0] r_samp [$];
    logic [16:0] r_phase [$];
    logic [39:0] acc_seen [$];

    dsp i_dsp (.*);

    always #4 dspif = ~dspif;

    always @(posedge dspif) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run went past %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // Outputs are stable at the falling edge
    always @(negedge dspif) begin
        if (rst_n) begin
            // Time base advances by one every cycle
            if (tcnt_seen) begin
                check_eq("tcnt", tcnt, 32'(prev_tcnt + 1));
            end
            prev_tcnt = tcnt;
            tcnt_seen = 1'b1;
            if (qdrv_valid) begin
                q_samp.push_back(qdrv_sample);
                q_phase.push_back(qdrv_phase);
                q_time.push_back(tcnt);
            end
            if (rdrv_valid) begin
                r_samp.push_back(rdrv_sample);
                r_phase.push_back(rdrv_phase);
            end
            if (acc_valid) acc_seen.push_back(acc_x);
            if (cmd_credit) returned++;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int credits();
        return dsp_pkg::CMD_DEPTH - sent + returned;
    endfunction

    function automatic logic [15:0] scaled(input logic [15:0] d, input logic [15:0] a);
        logic signed [31:0] p;
        p = $signed(d) * $signed(a);
        p = p >>> dsp_pkg::SAMPLE_SHIFT;
        return p[15:0];
    endfunction

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_cond(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("At %0t the check failed: %s", $time, msg);
        end
    endtask

    task automatic check_reset_outputs();
        check_eq("tcnt in reset", tcnt, 0);
        check_eq("cmd_credit in reset", cmd_credit, 0);
        check_eq("qdrv_valid in reset", qdrv_valid, 0);
        check_eq("rdrv_valid in reset", rdrv_valid, 0);
        check_eq("acc_valid in reset", acc_valid, 0);
    endtask

    function automatic logic [127:0] make_cmd(input logic [31:0] trig, input logic [8:0] freq,
        input logic [16:0] phase, input logic [15:0] amp, input logic [3:0] cfg,
        input logic [1:0] sel, input int start, input int len);
        logic [127:0]       c;
        dsp_pkg::env_word_u w;
        w = '0;
        if (sel == dsp_pkg::ELEM_QDRV) begin
            w.q.start  = 10'(start);
            w.q.length = 10'(len);
        end else begin
            w.rd.start  = 12'(start);
            w.rd.length = 12'(len);
        end
        c = '0;
        c[dsp_pkg::CMD_TIME_LSB +: dsp_pkg::TIME_W]     = trig;
        c[dsp_pkg::CMD_FREQ_LSB +: dsp_pkg::FREQ_W]     = freq;
        c[dsp_pkg::CMD_PHASE_LSB +: dsp_pkg::PHASE_W]   = phase;
        c[dsp_pkg::CMD_AMP_LSB +: dsp_pkg::AMP_W]       = amp;
        c[dsp_pkg::CMD_CFG_LSB +: dsp_pkg::CFG_W]       = cfg;
        c[dsp_pkg::CMD_ENV_LSB +: dsp_pkg::ENV_WORD_W] = w;
        return c;
    endfunction

    // Host holds back while it has no credit
    task automatic send_cmd(input logic [127:0] c);
        @(negedge dspif);
        while (credits() == 0) begin
            cmd_valid = 1'b0;
            @(negedge dspif);
        end
        cmd_valid = 1'b1;
        cmd = c;
        sent++;
    endtask

    task automatic end_cmds();
        @(negedge dspif);
        cmd_valid = 1'b0;
    endtask

    task automatic load_env(input logic [1:0] sel, input int start, input int len);
        logic [31:0] v;
        for (int i = 0; i < len; i++) begin
            @(negedge dspif);
            rand_bits(16, v);
            env_we = 1'b1;
            env_sel = sel;
            env_waddr = 12'(start + i);
            env_wdata = v[15:0];
            env_model[sel][12'(start + i)] = v[15:0];
        end
        @(negedge dspif);
        env_we = 1'b0;
    endtask

    task automatic clear_seen();
        q_samp.delete();
        q_phase.delete();
        q_time.delete();
        r_samp.delete();
        r_phase.delete();
        acc_seen.delete();
    endtask

    task automatic wait_samples(input bit rd, input int n, input int limit);
        int k;
        k = 0;
        while ((rd ? r_samp.size() : q_samp.size()) < n && k < limit) begin
            @(negedge dspif);
            k++;
        end
        check_cond(k < limit, "expected samples did not arrive in time");
        repeat (6) @(negedge dspif);
        check_eq("sample count", rd ? r_samp.size() : q_samp.size(), n);
    endtask

    task automatic check_samples(input bit rd, input int base, input logic [1:0] sel,
        input int start, input int len, input logic [15:0] amp, input logic [8:0] freq,
        input logic [16:0] phase);
        logic [15:0] s;
        logic [16:0] p;
        for (int k = 0; k < len; k++) begin
            s = rd ? r_samp[base + k] : q_samp[base + k];
            p = rd ? r_phase[base + k] : q_phase[base + k];
            check_eq($sformatf("sample %0d", k), s, scaled(env_model[sel][12'(start + k)], amp));
            check_eq($sformatf("phase %0d", k), p, 17'(phase + 17'(k) * 17'(freq)));
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_qdrv();
        logic [31:0] v;
        logic [15:0] amp;
        logic [8:0]  freq;
        logic [16:0] phase;
        load_env(dsp_pkg::ELEM_QDRV, 100, 40);
        rand_bits(16, v);
        amp = v[15:0];
        rand_bits(9, v);
        freq = v[8:0];
        rand_bits(17, v);
        phase = v[16:0];
        clear_seen();
        send_cmd(make_cmd(tcnt, freq, phase, amp, 4'd0, dsp_pkg::ELEM_QDRV, 100, 40));
        end_cmds();
        wait_samples(1'b0, 40, 200);
        check_samples(1'b0, 0, dsp_pkg::ELEM_QDRV, 100, 40, amp, freq, phase);
    endtask

    task automatic test_rdrv();
        logic [31:0] v;
        logic [15:0] amp;
        load_env(dsp_pkg::ELEM_RDRV, 2900, 1030);
        rand_bits(16, v);
        amp = v[15:0];
        clear_seen();
        send_cmd(make_cmd(tcnt, 9'd301, 17'h1fff0, amp, 4'd1, dsp_pkg::ELEM_RDRV, 2900, 1030));
        end_cmds();
        wait_samples(1'b1, 1030, 1200);
        check_samples(1'b1, 0, dsp_pkg::ELEM_RDRV, 2900, 1030, amp, 9'd301, 17'h1fff0);
        check_cond(q_samp.size() == 0, "qdrv produced samples on an rdrv command");
    endtask

    task automatic test_readout();
        logic [31:0]        v;
        logic [31:0]        trig;
        logic [15:0]        amp;
        logic signed [31:0] mix;
        logic [39:0]        sum;
        int                 k;
        load_env(dsp_pkg::ELEM_RDLO, 500, 16);
        rand_bits(16, v);
        amp = v[15:0];
        clear_seen();
        adc_hist.delete();
        trig = tcnt + 12;
        send_cmd(make_cmd(trig, 9'd17, 17'd0, amp, 4'd2, dsp_pkg::ELEM_RDLO, 500, 16));
        end_cmds();
        k = 0;
        while (k < 60) begin
            @(negedge dspif);
            rand_bits(16, v);
            adc = v[15:0];
            adc_hist[int'(tcnt)] = v[15:0];
            k++;
        end
        // Sample k of the pulse is present at tcnt = trig + 3 + k
        sum = '0;
        for (int i = 0; i < 16; i++) begin
            check_cond(adc_hist.exists(int'(trig) + 3 + i), "ADC history misses a sample cycle");
            mix = $signed(adc_hist[int'(trig) + 3 + i]) *
                  $signed(scaled(env_model[dsp_pkg::ELEM_RDLO][12'(500 + i)], amp));
            mix = mix >>> dsp_pkg::MIX_SHIFT;
            sum = sum + {{8{mix[31]}}, mix};
        end
        check_eq("acc_valid pulses", acc_seen.size(), 1);
        if (acc_seen.size() > 0) check_eq("acc_x", acc_seen[0], sum);
        check_cond(q_samp.size() == 0 && r_samp.size() == 0, "drive samples during readout");
    endtask

    task automatic test_trigger();
        logic [31:0] t0;
        load_env(dsp_pkg::ELEM_QDRV, 200, 16);
        clear_seen();
        t0 = tcnt + 30;
        send_cmd(make_cmd(t0, 9'd5, 17'd7, 16'h4000, 4'd0, dsp_pkg::ELEM_QDRV, 200, 8));
        send_cmd(make_cmd(t0 + 50, 9'd9, 17'd3, 16'hc000, 4'd0, dsp_pkg::ELEM_QDRV, 208, 8));
        end_cmds();
        wait_samples(1'b0, 16, 300);
        if (q_samp.size() == 16) begin
            check_cond(q_time[0] >= t0 + 2, "first pulse played before its trigger time");
            check_cond(q_time[8] >= t0 + 52, "second pulse played before its trigger time");
            check_samples(1'b0, 0, dsp_pkg::ELEM_QDRV, 200, 8, 16'h4000, 9'd5, 17'd7);
            check_samples(1'b0, 8, dsp_pkg::ELEM_QDRV, 208, 8, 16'hc000, 9'd9, 17'd3);
        end
    endtask

    task automatic test_credits();
        int k;
        clear_seen();
        for (int i = 0; i < 4; i++) begin
            send_cmd(make_cmd(32'd0, 9'd1, 17'd0, 16'h1000, 4'd3, dsp_pkg::ELEM_QDRV, 0, 4));
        end
        end_cmds();
        k = 0;
        while (credits() != dsp_pkg::CMD_DEPTH && k < 50) begin
            @(negedge dspif);
            k++;
        end
        check_eq("host credits", credits(), dsp_pkg::CMD_DEPTH);
        repeat (10) @(negedge dspif);
        check_cond(q_samp.size() == 0 && r_samp.size() == 0 && acc_seen.size() == 0,
                   "dropped command produced output");
    endtask

    initial begin
        rst_n = 1'b1;
        cmd_valid = 1'b0;
        cmd = '0;
        env_we = 1'b0;
        env_sel = 2'd0;
        env_waddr = '0;
        env_wdata = '0;
        adc = '0;
        #1 rst_n = 1'b0;
        repeat (5) @(posedge dspif);
        @(negedge dspif);
        check_reset_outputs();
        rst_n = 1'b1;
        test_qdrv();
        test_rdrv();
        test_readout();
        test_trigger();
        test_credits();
        repeat (5) @(negedge dspif);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/dsp_pkg.sv
rtl/proc_core.sv
rtl/envelope_mem.sv
rtl/pulse_element.sv
rtl/readout_acc.sv
rtl/dsp.sv
test/dsp_assertions.sv
test/dsp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dsp_tb
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
